/* common/fetch_defs.svh */
// Fetch and cache geometry; line words and set count must be powers of two, PC is word aligned
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Physical address width, equal to the PC width
`define FETCH_ADDR_WIDTH 32

// Words of 32 bits in one cache line
`define FETCH_LINE_WORDS 4

// Set index bits, 16 sets
`define FETCH_INDEX_WIDTH 4

// PC after reset
`define FETCH_INITIAL_PC 32'h0000_1000

// Cycles without a lookup after a flush
`define FETCH_FLUSH_STALL 2

`endif

/* common/fetchPkg.sv */
// Cache address and controller types; the tag takes every address bit above index and offsets
`include "fetch_defs.svh"

`default_nettype none

package fetchPkg;

    localparam int wordOffsetWidth = $clog2(`FETCH_LINE_WORDS);
    localparam int tagWidth = `FETCH_ADDR_WIDTH - `FETCH_INDEX_WIDTH - wordOffsetWidth - 2;
    localparam int lineWidth = `FETCH_LINE_WORDS * 32;

    typedef logic [tagWidth-1:0] tagT;
    typedef logic [`FETCH_INDEX_WIDTH-1:0] indexT;
    typedef logic [lineWidth-1:0] lineT;

    // PC and line address, seen either as a plain word or split into cache fields
    typedef union packed {
        logic [`FETCH_ADDR_WIDTH-1:0] raw;
        struct packed {
            tagT                        tag;
            indexT                      index;
            logic [wordOffsetWidth-1:0] wordOffset;
            logic [1:0]                 byteOffset;
        } fields;
    } fetchAddrT;

    typedef enum logic [1:0] {
        stateDefault    = 2'h0,
        stateInvalidate = 2'h1,
        stateReplace    = 2'h2
    } fetchStateT;

endpackage

`default_nettype wire

/* common/axiLitePkg.sv */
// AXI4-Lite read response codes only; no write channel types
`default_nettype none

package axiLitePkg;

    typedef enum logic [1:0] {
        respOkay   = 2'b00,
        respExOkay = 2'b01,
        respSlvErr = 2'b10,
        respDecErr = 2'b11
    } respT;

    // SLVERR and DECERR both mean the data beat is unusable
    function automatic logic isErrorResp(input respT resp);
        return (resp == respSlvErr) || (resp == respDecErr);
    endfunction

endpackage

`default_nettype wire

/* fetch/lineArray.sv */
// Valid/tag/data set array with one-cycle read; a read in a write cycle returns the old entry
`include "fetch_defs.svh"

`timescale 1ns/1ns
`default_nettype none

module lineArray (
    input  logic            clk,
    input  logic            rst,
    input  fetchPkg::indexT index,
    input  logic            writeEnable,
    input  logic            writeValid,
    input  fetchPkg::tagT   writeTag,
    input  fetchPkg::lineT  writeLine,
    output logic            readValid,
    output fetchPkg::tagT   readTag,
    output fetchPkg::lineT  readLine
);
    import fetchPkg::*;

    localparam int numSets = 1 << `FETCH_INDEX_WIDTH;

    logic [numSets-1:0] validBits;
    tagT                tagMem [numSets];
    lineT               dataMem [numSets];

    // Valid bit per set, with its registered read
    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            readValid <= 1'b0;
        end else begin
            readValid <= validBits[index];
            if (writeEnable) begin
                validBits[index] <= writeValid;
            end
        end
    end

    always_ff @(posedge clk) begin
        readTag <= tagMem[index];
        readLine <= dataMem[index];
        if (writeEnable) begin
            tagMem[index] <= writeTag;
            dataMem[index] <= writeLine;
        end
    end

endmodule

`default_nettype wire

/* fetch/iCacheInvalidater.sv */
// Clears every valid bit, one set per enabled cycle; a request during a walk merges into it
`timescale 1ns/1ns
`default_nettype none

module iCacheInvalidater (
    input  logic            clk,
    input  logic            rst,
    input  logic            enable,
    input  logic            request,
    output fetchPkg::indexT index,
    output logic            writeEnable,
    output logic            waitInvalidate,
    output logic            done
);
    import fetchPkg::*;

    indexT setCount;
    logic  pending;

    always_comb begin
        index = setCount;
        writeEnable = enable;
        done = enable && (setCount == '1);
        waitInvalidate = pending;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            setCount <= '0;
            pending <= 1'b0;
        end else begin
            if (done) begin
                setCount <= '0;
            end else if (enable) begin
                setCount <= setCount + 1'b1;
            end

            // Held until the walk finishes, so a refill in progress is not disturbed
            if (request) begin
                pending <= 1'b1;
            end else if (done) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* fetch/iCacheReplacer.sv */
// AXI4-Lite line refill, one read outstanding; missAddr is sampled only in the first enabled cycle
`include "fetch_defs.svh"

`timescale 1ns/1ns
`default_nettype none

module iCacheReplacer (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  fetchPkg::fetchAddrT missAddr,
    output fetchPkg::indexT     index,
    output logic                writeEnable,
    output fetchPkg::tagT       writeTag,
    output fetchPkg::lineT      writeLine,
    output logic                done,
    output logic                error,
    output logic                arvalid,
    output logic [31:0]         araddr,
    input  logic                arready,
    input  logic                rvalid,
    input  logic [31:0]         rdata,
    input  axiLitePkg::respT    rresp,
    output logic                rready
);
    import fetchPkg::*;
    import axiLitePkg::*;

    localparam logic [wordOffsetWidth-1:0] lastBeat = wordOffsetWidth'(`FETCH_LINE_WORDS - 1);

    logic                       active;
    logic                       dataPhase;
    logic [wordOffsetWidth-1:0] beat;
    tagT                        baseTag;
    indexT                      baseIndex;
    logic                       errSticky;
    logic                       lastData;

    // Earlier words of the line; the last one goes straight from rdata into the array
    logic [(`FETCH_LINE_WORDS-1)*32-1:0] wordBuf;

    always_comb begin
        arvalid = active && !dataPhase;
        araddr = {baseTag, baseIndex, beat, 2'b00};
        rready = active && dataPhase;

        lastData = active && dataPhase && rvalid && (beat == lastBeat);
        writeEnable = lastData;
        done = lastData;
        error = errSticky || isErrorResp(rresp);

        index = baseIndex;
        writeTag = baseTag;
        writeLine = {rdata, wordBuf};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            dataPhase <= 1'b0;
            beat <= '0;
            errSticky <= 1'b0;
        end else if (!active) begin
            // Start a refill of the line holding missAddr
            if (enable) begin
                active <= 1'b1;
                dataPhase <= 1'b0;
                beat <= '0;
                errSticky <= 1'b0;
            end
        end else if (!dataPhase) begin
            if (arready) begin
                dataPhase <= 1'b1;
            end
        end else if (rvalid) begin
            dataPhase <= 1'b0;
            if (isErrorResp(rresp)) begin
                errSticky <= 1'b1;
            end
            if (beat == lastBeat) begin
                active <= 1'b0;
            end else begin
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && enable) begin
            baseTag <= missAddr.fields.tag;
            baseIndex <= missAddr.fields.index;
        end
        if (active && dataPhase && rvalid && beat != lastBeat) begin
            wordBuf[{beat, 5'b0} +: 32] <= rdata;
        end
    end

endmodule

`default_nettype wire

/* fetch/fetchUnit.sv */
// Fetch stage over a direct-mapped I-cache; 4-byte PC steps only, flush target must be word aligned
`include "fetch_defs.svh"

`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                flush,
    input  logic                invalidate,
    input  fetchPkg::fetchAddrT nextPc,
    output logic                valid,
    output logic                fault,
    output fetchPkg::fetchAddrT pc,
    output logic [31:0]         instr,
    output logic                arvalid,
    output logic [31:0]         araddr,
    input  logic                arready,
    input  logic                rvalid,
    input  logic [31:0]         rdata,
    input  axiLitePkg::respT    rresp,
    output logic                rready
);
    import fetchPkg::*;

    localparam int stallCountWidth = $clog2(`FETCH_FLUSH_STALL) + 1;

    fetchStateT                 state;
    fetchStateT                 stateNext;
    fetchAddrT                  pcNext;
    logic                       lookup;
    logic                       lookupNext;
    logic                       faultReg;
    logic                       faultNext;
    logic [stallCountWidth-1:0] stallCount;
    logic [stallCountWidth-1:0] stallCountNext;

    logic cacheMiss;
    logic holdFetch;
    logic goInvalidate;

    indexT arrayIndex;
    logic  arrayWriteEnable;
    logic  arrayWriteValid;
    logic  arrayReadValid;
    tagT   arrayReadTag;
    lineT  arrayReadLine;

    indexT invIndex;
    logic  invWriteEnable;
    logic  waitInvalidate;
    logic  invDone;

    indexT repIndex;
    logic  repWriteEnable;
    tagT   repWriteTag;
    lineT  repWriteLine;
    logic  repDone;
    logic  repError;

    lineArray array (
        .clk,
        .rst,
        .index(arrayIndex),
        .writeEnable(arrayWriteEnable),
        .writeValid(arrayWriteValid),
        .writeTag(repWriteTag),
        .writeLine(repWriteLine),
        .readValid(arrayReadValid),
        .readTag(arrayReadTag),
        .readLine(arrayReadLine)
    );

    iCacheInvalidater invalidater (
        .clk,
        .rst,
        .enable(state == stateInvalidate),
        .request(invalidate),
        .index(invIndex),
        .writeEnable(invWriteEnable),
        .waitInvalidate,
        .done(invDone)
    );

    iCacheReplacer replacer (
        .clk,
        .rst,
        .enable(state == stateReplace),
        .missAddr(pc),
        .index(repIndex),
        .writeEnable(repWriteEnable),
        .writeTag(repWriteTag),
        .writeLine(repWriteLine),
        .done(repDone),
        .error(repError),
        .arvalid,
        .araddr,
        .arready,
        .rvalid,
        .rdata,
        .rresp,
        .rready
    );

    always_comb begin
        cacheMiss = lookup && (!arrayReadValid || arrayReadTag != pc.fields.tag);
        valid = (lookup && !cacheMiss) || faultReg;
        fault = faultReg;
        instr = arrayReadLine[{pc.fields.wordOffset, 5'b0} +: 32];
        holdFetch = stall || (stallCount != '0);
        // Do not drop a shown instruction that decode is still holding
        goInvalidate = waitInvalidate && !(valid && stall);
    end

    always_comb begin
        if (flush) begin
            pcNext.raw = nextPc.raw;
        end else if (holdFetch || !valid || faultReg || state != stateDefault) begin
            pcNext.raw = pc.raw;
        end else begin
            pcNext.raw = pc.raw + 32'd4;
        end
    end

    // Array port ownership by state
    always_comb begin
        case (state)
            stateInvalidate: begin
                arrayIndex = invIndex;
                arrayWriteEnable = invWriteEnable;
                arrayWriteValid = 1'b0;
            end
            stateReplace: begin
                arrayIndex = repIndex;
                arrayWriteEnable = repWriteEnable;
                arrayWriteValid = !repError;
            end
            default: begin
                arrayIndex = pcNext.fields.index;
                arrayWriteEnable = 1'b0;
                arrayWriteValid = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (state)
            stateInvalidate: stateNext = invDone ? stateDefault : stateInvalidate;
            stateReplace:    stateNext = repDone ? stateDefault : stateReplace;
            default: begin
                if (goInvalidate) begin
                    stateNext = stateInvalidate;
                end else if (cacheMiss && !flush) begin
                    stateNext = stateReplace;
                end else begin
                    stateNext = stateDefault;
                end
            end
        endcase

        lookupNext = (state == stateDefault) && (stateNext == stateDefault) && !flush
            && (stallCount == '0) && !faultReg;

        if (flush) begin
            faultNext = 1'b0;
        end else if (state == stateReplace && repDone && repError) begin
            faultNext = 1'b1;
        end else begin
            faultNext = faultReg;
        end

        if (flush) begin
            stallCountNext = stallCountWidth'(`FETCH_FLUSH_STALL);
        end else if (stallCount != '0) begin
            stallCountNext = stallCount - 1'b1;
        end else begin
            stallCountNext = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stateDefault;
            pc.raw <= `FETCH_INITIAL_PC;
            lookup <= 1'b0;
            faultReg <= 1'b0;
            stallCount <= '0;
        end else begin
            state <= stateNext;
            pc <= pcNext;
            lookup <= lookupNext;
            faultReg <= faultNext;
            stallCount <= stallCountNext;
        end
    end

endmodule

`default_nettype wire

/* verif/fetchChecker.sv */
// Fetch output and AXI read channel watcher; memory contents are address XOR A5A5_0000, one DUT only
`include "fetch_defs.svh"

`timescale 1ns/1ns
`default_nettype none

module fetchChecker (
    input logic                clk,
    input logic                rst,
    input logic                stall,
    input logic                flush,
    input fetchPkg::fetchAddrT nextPc,
    input logic                valid,
    input logic                fault,
    input fetchPkg::fetchAddrT pc,
    input logic [31:0]         instr,
    input logic                arvalid,
    input logic [31:0]         araddr,
    input logic                arready,
    input logic                rvalid,
    input logic                rready,
    input axiLitePkg::respT    rresp
);
    import axiLitePkg::*;

    int checkCount = 0;
    int errorCount = 0;
    int testCount = 0;
    int testErrors = 0;
    int arCount = 0;
    int arAtOpen = 0;
    int flushWait;
    int resetWait;

    logic [31:0] expectPc;
    logic        expectFault;
    logic        faultHeld;
    logic        held;
    logic [31:0] heldPc;
    logic [31:0] heldInstr;
    logic        heldFault;
    logic        arPending;
    logic [31:0] arPendingAddr;
    logic        readOutstanding;

    // Word the memory holds at an address
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            testErrors++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic openTest();
        arAtOpen = arCount;
        testErrors = 0;
    endtask

    // Negative expectedAr skips the refill count
    task automatic closeTest(input string name, input int expectedAr);
        if (expectedAr >= 0) begin
            compareValue("AR handshakes", expectedAr, arCount - arAtOpen);
        end
        testCount++;
        $display("Test %0d %s: %0d AR handshakes, %0d errors", testCount, name,
                 arCount - arAtOpen, testErrors);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            expectPc = `FETCH_INITIAL_PC;
            expectFault = 1'b0;
            faultHeld = 1'b0;
            flushWait = 0;
            held = 1'b0;
            arPending = 1'b0;
            readOutstanding = 1'b0;
            resetWait = 2;
        end else begin
            // Outputs stay quiet in the last reset cycle and the one after
            if (resetWait > 0) begin
                compareValue("valid", 0, valid);
                compareValue("fault", 0, fault);
                compareValue("arvalid", 0, arvalid);
                resetWait--;
            end
            // Address must stay put until accepted
            if (arPending) begin
                compareValue("arvalid", 1, arvalid);
                compareValue("araddr", arPendingAddr, araddr);
            end
            arPending = arvalid && !arready;
            arPendingAddr = araddr;
            // rready only while a read waits for its R beat
            if (!readOutstanding) begin
                compareValue("rready", 0, rready);
            end else if (rvalid) begin
                compareValue("rready", 1, rready);
            end
            if (arvalid && arready) begin
                arCount++;
                readOutstanding = 1'b1;
            end
            if (rvalid && rready) begin
                readOutstanding = 1'b0;
            end
            if (rvalid && rready && isErrorResp(rresp)) begin
                expectFault = 1'b1;
            end

            if (flushWait > 0) begin
                compareValue("valid", 0, valid);
                flushWait--;
            end
            if (held) begin
                compareValue("valid", 1, valid);
                compareValue("pc", heldPc, pc.raw);
                compareValue("instr", heldInstr, instr);
                compareValue("fault", heldFault, fault);
            end
            if (faultHeld) begin
                compareValue("valid", 1, valid);
            end
            if (valid) begin
                compareValue("pc", expectPc, pc.raw);
                compareValue("fault", expectFault, fault);
                if (!fault) begin
                    compareValue("instr", memWord(expectPc), instr);
                end
            end

            held = valid && stall && !flush;
            heldPc = pc.raw;
            heldInstr = instr;
            heldFault = fault;
            faultHeld = (faultHeld || (valid && fault)) && !flush;

            if (flush) begin
                expectPc = nextPc.raw;
                expectFault = 1'b0;
                flushWait = `FETCH_FLUSH_STALL;
            end else if (valid && !stall && !fault) begin
                expectPc = expectPc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/fetchTb.sv */
// Testbench top; memory answers SLVERR from 0x8000 up, with 0 to 3 cycles of arready/rvalid delay
`include "fetch_defs.svh"

`timescale 1ns/1ns
`default_nettype none

module fetchTb;
    import fetchPkg::*;
    import axiLitePkg::*;

    localparam logic [31:0] seed = 32'h8fa2037e;
    localparam logic [31:0] faultAddr = 32'h0000_8000;
    localparam logic [31:0] loopBase = 32'h0000_2000;
    // Fetches in all tests, each bounded by a lookup plus a refill at the longest delays
    localparam int fetchTotal = 137;
    localparam int worstFetchCycles = `FETCH_LINE_WORDS * 8 + `FETCH_FLUSH_STALL + 6;
    localparam int extraCycles = 12 * 4 + 16 + 8 + 16;
    localparam int cycleLimit = fetchTotal * worstFetchCycles + extraCycles;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        flush;
    logic        invalidate;
    fetchAddrT   nextPc;
    logic        valid;
    logic        fault;
    fetchAddrT   pc;
    logic [31:0] instr;
    logic        arvalid;
    logic [31:0] araddr;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    respT        rresp;
    logic        rready;
    logic [31:0] memSeed = seed;
    logic [31:0] stimSeed = seed;
    int          cycles = 0;

    fetchUnit UUT (.*);

    fetchChecker watcher (.*);

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    // One AR handshake then one R beat
    task automatic serveRead();
        logic [31:0] addr;
        memSeed = lcgNext(memSeed);
        repeat (memSeed[17:16]) @(negedge clk);
        addr = araddr;
        arready = 1'b1;
        @(negedge clk);
        arready = 1'b0;
        memSeed = lcgNext(memSeed);
        repeat (memSeed[17:16]) @(negedge clk);
        rvalid = 1'b1;
        rdata = watcher.memWord(addr);
        rresp = (addr >= faultAddr) ? respSlvErr : respOkay;
        @(negedge clk);
        rvalid = 1'b0;
        rdata = '0;
        rresp = respOkay;
    endtask

    initial begin
        @(negedge clk);
        forever begin
            if (!rst && arvalid) begin
                serveRead();
            end else begin
                @(negedge clk);
            end
        end
    end

    task automatic flushTo(input logic [31:0] target);
        nextPc.raw = target;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // Returns on the falling edge right after the last consumed instruction
    task automatic runFetches(input int count);
        int seen;
        seen = 0;
        while (seen < count) begin
            @(posedge clk);
            if (valid && !stall && !flush) begin
                seen++;
            end
        end
        @(negedge clk);
    endtask

    task automatic waitFault();
        @(posedge clk);
        while (!(valid && fault)) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        invalidate = 1'b0;
        nextPc.raw = '0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = respOkay;
        watcher.openTest();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        runFetches(40);
        watcher.closeTest("sequential fetch", 40);

        watcher.openTest();
        repeat (2) begin
            stimSeed = lcgNext(stimSeed);
            flushTo({20'h00003, stimSeed[25:16], 2'b00});
            runFetches(8);
        end
        watcher.closeTest("flush redirect", -1);

        watcher.openTest();
        flushTo(`FETCH_INITIAL_PC);
        repeat (12) begin
            stimSeed = lcgNext(stimSeed);
            stall = 1'b1;
            repeat (1 + stimSeed[17:16]) @(negedge clk);
            stall = 1'b0;
            runFetches(2);
        end
        watcher.closeTest("stall spans", -1);

        // Four lines, four reads each
        watcher.openTest();
        flushTo(loopBase);
        runFetches(16);
        watcher.closeTest("loop first pass", 16);
        watcher.openTest();
        flushTo(loopBase);
        runFetches(16);
        watcher.closeTest("loop second pass", 0);

        watcher.openTest();
        nextPc.raw = loopBase;
        flush = 1'b1;
        invalidate = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        invalidate = 1'b0;
        runFetches(16);
        watcher.closeTest("refetch after invalidate", 16);

        // Error line plus two fresh lines at the initial PC
        watcher.openTest();
        flushTo(faultAddr);
        waitFault();
        repeat (5) @(negedge clk);
        flushTo(`FETCH_INITIAL_PC);
        runFetches(8);
        watcher.closeTest("refill error", 12);

        $display("Tests %0d, checks %0d, errors %0d", watcher.testCount, watcher.checkCount,
                 watcher.errorCount);
        if (watcher.errorCount == 0 && watcher.checkCount > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/fetchPkg.sv
common/axiLitePkg.sv
fetch/lineArray.sv
fetch/iCacheInvalidater.sv
fetch/iCacheReplacer.sv
fetch/fetchUnit.sv
verif/fetchChecker.sv
verif/fetchTb.sv

/* Bender.yml */
package:
  name: fetch_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fetchPkg.sv
      - common/axiLitePkg.sv
      - fetch/lineArray.sv
      - fetch/iCacheInvalidater.sv
      - fetch/iCacheReplacer.sv
      - fetch/fetchUnit.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/fetchChecker.sv
      - verif/fetchTb.sv
